// File: source/axi_lite_pkg.sv
// AXI4-Lite bus definitions shared by the interposer and the register block
// fixed widths, per-channel payload structs and the response code
package axi_lite_pkg;

  localparam int AXI_ADDR_W = 12;             // byte address
  localparam int AXI_DATA_W = 32;
  localparam int AXI_STRB_W = AXI_DATA_W / 8; // one strobe per byte

  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [AXI_STRB_W-1:0] axi_strb_t;

  // only OKAY and SLVERR are ever produced
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  typedef struct packed {
    axi_addr_t  addr;
    logic [2:0] prot; // carried across, never decoded
  } aw_chan_t;

  typedef struct packed {
    axi_addr_t  addr;
    logic [2:0] prot;
  } ar_chan_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
  } w_chan_t;

  typedef struct packed {
    axi_resp_e resp;
  } b_chan_t;

  typedef struct packed {
    axi_data_t data;
    axi_resp_e resp;
  } r_chan_t;

endpackage

// File: source/periph_regs_pkg.sv
// register map of the peripheral register block
// word indices, identification value and the write/read FSM states
package periph_regs_pkg;

  // word index = byte address / 4
  typedef enum logic [3:0] {
    REG_ID      = 4'd0, // read only, returns PERIPH_ID
    REG_CTRL    = 4'd1,
    REG_SCRATCH = 4'd2  // indices above are plain r/w words
  } periph_reg_e;

  localparam logic [31:0] PERIPH_ID = 32'hC0DE_0A11;

  // write side waits for both AW and W before acting
  typedef enum logic {
    WR_COLLECT,
    WR_RESP
  } wr_state_e;

  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_e;

endpackage

// File: source/axi_channel_xdomain.sv
// single-entry crossing for one AXI channel between two clocks
// toggle request/acknowledge handshake, two-flop synchronizers,
// reset release synchronized separately into each clock
`timescale 1ns/1ns

module axi_channel_xdomain #(
  parameter type chan_t = logic
) (
  input  logic  clka,
  input  logic  clkb,
  input  logic  arst_n,
  input  chan_t dataa,
  input  logic  valida,
  output logic  readya,
  output chan_t datab,
  output logic  validb,
  input  logic  readyb
);

  logic [1:0] rsta_sync;  // reset release, clka side
  logic [1:0] rstb_sync;  // reset release, clkb side
  logic       rsta_n;
  logic       rstb_n;
  chan_t      hold_q;     // the single entry
  logic       req_a;      // flips per accepted item
  logic [1:0] ack_sync_a; // ack_b seen on clka
  logic [1:0] req_sync_b; // req_a seen on clkb
  logic       ack_b;      // flips per delivered item

  always_ff @(posedge clka or negedge arst_n) begin
    if (!arst_n) begin
      rsta_sync <= 2'b00;
    end else begin
      rsta_sync <= {rsta_sync[0], 1'b1}; // async assert, sync release
    end
  end
  assign rsta_n = rsta_sync[1];

  always_ff @(posedge clkb or negedge arst_n) begin
    if (!arst_n) begin
      rstb_sync <= 2'b00;
    end else begin
      rstb_sync <= {rstb_sync[0], 1'b1};
    end
  end
  assign rstb_n = rstb_sync[1];

  // a side: capture and raise request
  always_ff @(posedge clka) begin
    if (valida && readya)
      hold_q <= dataa; // capture on accept
  end

  always_ff @(posedge clka or negedge rsta_n) begin
    if (!rsta_n) begin
      req_a      <= 1'b0;
      ack_sync_a <= 2'b00;
    end else begin
      ack_sync_a <= {ack_sync_a[0], ack_b};
      if (valida && readya)
        req_a <= ~req_a; // readya drops on this edge
    end
  end
  assign readya = (req_a == ack_sync_a[1]); // idle once ack is back

  // b side: present until taken, then acknowledge
  always_ff @(posedge clkb or negedge rstb_n) begin
    if (!rstb_n) begin
      req_sync_b <= 2'b00;
      ack_b      <= 1'b0;
    end else begin
      req_sync_b <= {req_sync_b[0], req_a};
      if (validb && readyb)
        ack_b <= ~ack_b;
    end
  end
  assign validb = (req_sync_b[1] != ack_b);
  assign datab  = hold_q; // stable while request outstanding

  a_datab_hold: assert property (@(posedge clkb) disable iff (!rstb_n)
    validb && !readyb |=> validb && $stable(datab));

  // producer keeps its item steady while the entry is busy
  a_valida_hold: assert property (@(posedge clka) disable iff (!rsta_n)
    valida && !readya |=> valida && $stable(dataa));

endmodule

// File: source/axi_cdc.sv
// AXI4-Lite interposer between host clock and peripheral clock
// one crossing per channel: AW, W, AR forward, B and R back
`timescale 1ns/1ns

module axi_cdc
  import axi_lite_pkg::*;
(
  input  logic     s_axi_aclk,
  input  logic     m_axi_aclk,
  input  logic     arst_n,
  // host side
  input  aw_chan_t s_aw,
  input  logic     s_aw_valid,
  output logic     s_aw_ready,
  input  w_chan_t  s_w,
  input  logic     s_w_valid,
  output logic     s_w_ready,
  output b_chan_t  s_b,
  output logic     s_b_valid,
  input  logic     s_b_ready,
  input  ar_chan_t s_ar,
  input  logic     s_ar_valid,
  output logic     s_ar_ready,
  output r_chan_t  s_r,
  output logic     s_r_valid,
  input  logic     s_r_ready,
  // peripheral side
  output aw_chan_t m_aw,
  output logic     m_aw_valid,
  input  logic     m_aw_ready,
  output w_chan_t  m_w,
  output logic     m_w_valid,
  input  logic     m_w_ready,
  input  b_chan_t  m_b,
  input  logic     m_b_valid,
  output logic     m_b_ready,
  output ar_chan_t m_ar,
  output logic     m_ar_valid,
  input  logic     m_ar_ready,
  input  r_chan_t  m_r,
  input  logic     m_r_valid,
  output logic     m_r_ready
);

  // host to peripheral
  axi_channel_xdomain #(.chan_t(aw_chan_t)) xdomain_aw (
    .clka(s_axi_aclk), .clkb(m_axi_aclk), .arst_n(arst_n),
    .dataa(s_aw), .valida(s_aw_valid), .readya(s_aw_ready),
    .datab(m_aw), .validb(m_aw_valid), .readyb(m_aw_ready));

  axi_channel_xdomain #(.chan_t(w_chan_t)) xdomain_w (
    .clka(s_axi_aclk), .clkb(m_axi_aclk), .arst_n(arst_n),
    .dataa(s_w), .valida(s_w_valid), .readya(s_w_ready),
    .datab(m_w), .validb(m_w_valid), .readyb(m_w_ready));

  axi_channel_xdomain #(.chan_t(ar_chan_t)) xdomain_ar (
    .clka(s_axi_aclk), .clkb(m_axi_aclk), .arst_n(arst_n),
    .dataa(s_ar), .valida(s_ar_valid), .readya(s_ar_ready),
    .datab(m_ar), .validb(m_ar_valid), .readyb(m_ar_ready));

  // peripheral to host, clocks swapped
  axi_channel_xdomain #(.chan_t(b_chan_t)) xdomain_b (
    .clka(m_axi_aclk), .clkb(s_axi_aclk), .arst_n(arst_n),
    .dataa(m_b), .valida(m_b_valid), .readya(m_b_ready),
    .datab(s_b), .validb(s_b_valid), .readyb(s_b_ready));

  axi_channel_xdomain #(.chan_t(r_chan_t)) xdomain_r (
    .clka(m_axi_aclk), .clkb(s_axi_aclk), .arst_n(arst_n),
    .dataa(m_r), .valida(m_r_valid), .readya(m_r_ready),
    .datab(s_r), .validb(s_r_valid), .readyb(s_r_ready));

  a_host_valid_known: assert property (@(posedge s_axi_aclk) disable iff (!arst_n)
    !$isunknown({s_b_valid, s_r_valid, s_aw_ready, s_w_ready, s_ar_ready}));

  a_periph_valid_known: assert property (@(posedge m_axi_aclk) disable iff (!arst_n)
    !$isunknown({m_aw_valid, m_w_valid, m_ar_valid, m_b_ready, m_r_ready}));

endmodule

// File: source/periph_regs.sv
// AXI4-Lite register block on the peripheral clock
// ID word, NUM_REGS-1 writable words with byte strobes, SLVERR outside map
`timescale 1ns/1ns

module periph_regs
  import axi_lite_pkg::*;
  import periph_regs_pkg::*;
#(
  parameter int NUM_REGS = 8
) (
  input  logic     m_axi_aclk,
  input  logic     arst_n,
  input  aw_chan_t m_aw,
  input  logic     m_aw_valid,
  output logic     m_aw_ready,
  input  w_chan_t  m_w,
  input  logic     m_w_valid,
  output logic     m_w_ready,
  output b_chan_t  m_b,
  output logic     m_b_valid,
  input  logic     m_b_ready,
  input  ar_chan_t m_ar,
  input  logic     m_ar_valid,
  output logic     m_ar_ready,
  output r_chan_t  m_r,
  output logic     m_r_valid,
  input  logic     m_r_ready
);

  localparam int IDX_W = AXI_ADDR_W - 2; // word index bits

  axi_data_t        regs [1:NUM_REGS-1]; // index 0 is the ID constant
  aw_chan_t         aw_q;                // AW slot
  w_chan_t          w_q;                 // W slot
  ar_chan_t         ar_q;
  logic             aw_full;
  logic             w_full;
  wr_state_e        wr_state;
  rd_state_e        rd_state;
  logic [IDX_W-1:0] wr_idx;
  logic             wr_ok;

  function automatic r_chan_t read_word(input axi_addr_t addr);
    logic [IDX_W-1:0] idx;
    r_chan_t          r;
    idx    = addr[AXI_ADDR_W-1:2]; // bits 1:0 ignored
    r.data = '0;
    r.resp = RESP_SLVERR;           // default: outside the map
    if (idx == REG_ID) begin
      r.data = PERIPH_ID;
      r.resp = RESP_OKAY;
    end else if (idx < NUM_REGS) begin
      r.data = regs[idx];
      r.resp = RESP_OKAY;
    end
    return r;
  endfunction

  assign wr_idx     = aw_q.addr[AXI_ADDR_W-1:2];
  assign wr_ok      = (wr_idx != REG_ID) && (wr_idx < NUM_REGS); // ID is read only
  assign m_aw_ready = !aw_full && (wr_state == WR_COLLECT);
  assign m_w_ready  = !w_full && (wr_state == WR_COLLECT);
  assign m_ar_ready = (rd_state == RD_IDLE);

  always_ff @(posedge m_axi_aclk) begin
    if (m_aw_valid && m_aw_ready)
      aw_q <= m_aw;
    if (m_w_valid && m_w_ready)
      w_q <= m_w;
    if (m_ar_valid && m_ar_ready)
      ar_q <= m_ar;
  end

  // write FSM: fill both slots in any order, write, then respond
  always_ff @(posedge m_axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_state  <= WR_COLLECT;
      aw_full   <= 1'b0;
      w_full    <= 1'b0;
      m_b_valid <= 1'b0;
      m_b       <= '{resp: RESP_OKAY};
      for (int i = 1; i < NUM_REGS; i++)
        regs[i] <= '0;
    end else begin
      case (wr_state)
        WR_COLLECT: begin
          if (m_aw_valid && m_aw_ready)
            aw_full <= 1'b1;
          if (m_w_valid && m_w_ready)
            w_full <= 1'b1;
          if (aw_full && w_full) begin
            if (wr_ok) begin
              for (int b = 0; b < AXI_STRB_W; b++) begin
                if (w_q.strb[b])
                  regs[wr_idx][8*b +: 8] <= w_q.data[8*b +: 8]; // byte merge
              end
            end
            m_b.resp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
            m_b_valid <= 1'b1;
            wr_state  <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (m_b_ready) begin
            aw_full   <= 1'b0; // slots free again
            w_full    <= 1'b0;
            m_b_valid <= 1'b0;
            wr_state  <= WR_COLLECT;
          end
        end
        default: wr_state <= WR_COLLECT;
      endcase
    end
  end

  // read FSM: accept AR, look up on next edge, hold until taken
  always_ff @(posedge m_axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      rd_state  <= RD_IDLE;
      m_r_valid <= 1'b0;
      m_r       <= '{data: '0, resp: RESP_OKAY};
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (m_ar_valid)
            rd_state <= RD_RESP; // ready is high here
        end
        RD_RESP: begin
          if (!m_r_valid) begin
            m_r       <= read_word(ar_q.addr);
            m_r_valid <= 1'b1;
          end else if (m_r_ready) begin
            m_r_valid <= 1'b0;
            rd_state  <= RD_IDLE;
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  a_b_valid_state: assert property (@(posedge m_axi_aclk) disable iff (!arst_n)
    m_b_valid |-> wr_state == WR_RESP);

  a_r_hold: assert property (@(posedge m_axi_aclk) disable iff (!arst_n)
    m_r_valid && !m_r_ready |=> m_r_valid && $stable(m_r));

endmodule

// File: source/axi_cdc_regs_top.sv
// top level: host port on s_axi_aclk, register block on m_axi_aclk
// the clock crossing sits between the two
`timescale 1ns/1ns

module axi_cdc_regs_top
  import axi_lite_pkg::*;
#(
  parameter int NUM_REGS = 8
) (
  input  logic     s_axi_aclk,
  input  logic     m_axi_aclk,
  input  logic     arst_n,
  input  aw_chan_t s_aw,
  input  logic     s_aw_valid,
  output logic     s_aw_ready,
  input  w_chan_t  s_w,
  input  logic     s_w_valid,
  output logic     s_w_ready,
  output b_chan_t  s_b,
  output logic     s_b_valid,
  input  logic     s_b_ready,
  input  ar_chan_t s_ar,
  input  logic     s_ar_valid,
  output logic     s_ar_ready,
  output r_chan_t  s_r,
  output logic     s_r_valid,
  input  logic     s_r_ready
);

  aw_chan_t m_aw;  // peripheral-side channels
  w_chan_t  m_w;
  b_chan_t  m_b;
  ar_chan_t m_ar;
  r_chan_t  m_r;
  logic     m_aw_valid, m_aw_ready;
  logic     m_w_valid, m_w_ready;
  logic     m_b_valid, m_b_ready;
  logic     m_ar_valid, m_ar_ready;
  logic     m_r_valid, m_r_ready;

  axi_cdc i_axi_cdc (
    .s_axi_aclk(s_axi_aclk), .m_axi_aclk(m_axi_aclk), .arst_n(arst_n),
    .s_aw(s_aw), .s_aw_valid(s_aw_valid), .s_aw_ready(s_aw_ready),
    .s_w(s_w), .s_w_valid(s_w_valid), .s_w_ready(s_w_ready),
    .s_b(s_b), .s_b_valid(s_b_valid), .s_b_ready(s_b_ready),
    .s_ar(s_ar), .s_ar_valid(s_ar_valid), .s_ar_ready(s_ar_ready),
    .s_r(s_r), .s_r_valid(s_r_valid), .s_r_ready(s_r_ready),
    .m_aw(m_aw), .m_aw_valid(m_aw_valid), .m_aw_ready(m_aw_ready),
    .m_w(m_w), .m_w_valid(m_w_valid), .m_w_ready(m_w_ready),
    .m_b(m_b), .m_b_valid(m_b_valid), .m_b_ready(m_b_ready),
    .m_ar(m_ar), .m_ar_valid(m_ar_valid), .m_ar_ready(m_ar_ready),
    .m_r(m_r), .m_r_valid(m_r_valid), .m_r_ready(m_r_ready));

  periph_regs #(.NUM_REGS(NUM_REGS)) i_periph_regs (
    .m_axi_aclk(m_axi_aclk), .arst_n(arst_n),
    .m_aw(m_aw), .m_aw_valid(m_aw_valid), .m_aw_ready(m_aw_ready),
    .m_w(m_w), .m_w_valid(m_w_valid), .m_w_ready(m_w_ready),
    .m_b(m_b), .m_b_valid(m_b_valid), .m_b_ready(m_b_ready),
    .m_ar(m_ar), .m_ar_valid(m_ar_valid), .m_ar_ready(m_ar_ready),
    .m_r(m_r), .m_r_valid(m_r_valid), .m_r_ready(m_r_ready));

endmodule

// File: tb/tb_axi_tasks.svh
// host-side AXI4-Lite bus tasks, register model, LCG and checks
// tasks enter and leave 1 ns after a host clock edge
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

logic [31:0] lcg_state = 32'h28101962;
axi_data_t   model [NUM_REGS]; // expected register contents

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

function automatic void model_init();
  model[0] = PERIPH_ID;
  for (int i = 1; i < NUM_REGS; i++)
    model[i] = '0;
endfunction

function automatic axi_addr_t word_addr(input int idx);
  return axi_addr_t'(idx * 4);
endfunction

function automatic r_chan_t model_read(input axi_addr_t addr);
  int      idx;
  r_chan_t r;
  idx = addr >> 2; // byte lanes ignored
  r   = '{data: '0, resp: RESP_SLVERR};
  if (idx < NUM_REGS)
    r = '{data: model[idx], resp: RESP_OKAY};
  return r;
endfunction

function automatic axi_resp_e model_write(input axi_addr_t addr, input axi_data_t data,
                                          input axi_strb_t strb);
  int idx;
  idx = addr >> 2;
  if (idx < 1 || idx >= NUM_REGS)
    return RESP_SLVERR; // ID word or outside the map
  for (int b = 0; b < 4; b++)
    if (strb[b])
      model[idx][8*b +: 8] = data[8*b +: 8];
  return RESP_OKAY;
endfunction

task automatic compare_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
  if (act !== exp)
    report_failure($sformatf("Mismatch at %0t ns: %s expected %h, actual %h",
                             $time, name, exp, act));
endtask

task automatic compare_data(input string name, input axi_data_t exp, input axi_data_t act);
  if (act !== exp)
    report_failure($sformatf("Mismatch at %0t ns: %s expected %h, actual %h",
                             $time, name, exp, act));
endtask

task automatic next_cycle();
  @(posedge s_axi_aclk);
  #1;
endtask

task automatic send_aw(input axi_addr_t addr);
  logic rdy;
  s_aw.addr  = addr;
  s_aw.prot  = 3'b000;
  s_aw_valid = 1'b1;
  do begin
    rdy = s_aw_ready; // ready is stable between host edges
    next_cycle();
  end while (!rdy);
  s_aw_valid = 1'b0;
endtask

task automatic send_w(input axi_data_t data, input axi_strb_t strb);
  logic rdy;
  s_w.data  = data;
  s_w.strb  = strb;
  s_w_valid = 1'b1;
  do begin
    rdy = s_w_ready;
    next_cycle();
  end while (!rdy);
  s_w_valid = 1'b0;
endtask

task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb,
                         input logic w_first, input int delay, output b_chan_t b);
  if (w_first) begin
    send_w(data, strb);
    send_aw(addr);
  end else begin
    send_aw(addr);
    send_w(data, strb);
  end
  while (!s_b_valid)
    next_cycle();
  b = s_b;
  repeat (delay) begin // back-pressure, response must hold
    next_cycle();
    if (!s_b_valid)
      report_failure($sformatf("Error at %0t ns: write response dropped before it was taken",
                               $time));
    compare_resp("s_b.resp", b.resp, s_b.resp);
  end
  s_b_ready = 1'b1;
  next_cycle();
  s_b_ready = 1'b0;
endtask

task automatic axi_read(input axi_addr_t addr, input int delay, output r_chan_t r);
  logic rdy;
  s_ar.addr  = addr;
  s_ar.prot  = 3'b000;
  s_ar_valid = 1'b1;
  do begin
    rdy = s_ar_ready;
    next_cycle();
  end while (!rdy);
  s_ar_valid = 1'b0;
  while (!s_r_valid)
    next_cycle();
  r = s_r;
  repeat (delay) begin
    next_cycle();
    if (!s_r_valid)
      report_failure($sformatf("Error at %0t ns: read response dropped before it was taken",
                               $time));
    compare_resp("s_r.resp", r.resp, s_r.resp);
    compare_data("s_r.data", r.data, s_r.data);
  end
  s_r_ready = 1'b1;
  next_cycle();
  s_r_ready = 1'b0;
endtask

task automatic check_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb,
                           input logic w_first, input int delay);
  axi_resp_e exp;
  b_chan_t   b;
  exp = model_write(addr, data, strb);
  axi_write(addr, data, strb, w_first, delay, b);
  compare_resp("s_b.resp", exp, b.resp);
endtask

task automatic check_read(input axi_addr_t addr, input int delay);
  r_chan_t exp;
  r_chan_t r;
  exp = model_read(addr);
  axi_read(addr, delay, r);
  compare_resp("s_r.resp", exp.resp, r.resp);
  compare_data("s_r.data", exp.data, r.data);
endtask

task automatic test_reset_id();
  if (s_b_valid !== 1'b0 || s_r_valid !== 1'b0)
    report_failure($sformatf("Error at %0t ns: a response is valid right after reset", $time));
  if (s_aw_ready !== 1'b1 || s_w_ready !== 1'b1 || s_ar_ready !== 1'b1)
    report_failure($sformatf("Error at %0t ns: a request channel is not ready after reset",
                             $time));
  for (int i = 0; i < NUM_REGS; i++)
    check_read(word_addr(i), 0); // ID word, then zeros
endtask

task automatic test_write_read();
  check_write(word_addr(REG_CTRL), 32'h1234_5678, 4'hF, 1'b0, 0); // AW before W
  check_write(word_addr(REG_SCRATCH), 32'hA5A5_0F0F, 4'hF, 1'b1, 0); // W before AW
  check_read(word_addr(REG_CTRL), 0);
  check_read(word_addr(REG_SCRATCH), 0);
  check_write(word_addr(REG_CTRL), 32'h8765_4321, 4'hF, 1'b1, 0);
  check_read(word_addr(REG_CTRL), 0);
endtask

task automatic test_strobes();
  check_write(word_addr(3), 32'hFFFF_FFFF, 4'hF, 1'b0, 0);
  check_write(word_addr(3), 32'h0000_0012, 4'b0001, 1'b1, 0);
  check_read(word_addr(3), 0);
  check_write(word_addr(3), 32'h0034_5600, 4'b0110, 1'b0, 0);
  check_read(word_addr(3), 0);
  check_write(word_addr(3) | 12'h3, 32'h7800_0000, 4'b1000, 1'b1, 0); // low bits ignored
  check_read(word_addr(3), 0);
  check_write(word_addr(REG_SCRATCH), 32'hDEAD_BEEF, 4'b0101, 1'b0, 0);
  check_read(word_addr(REG_SCRATCH), 0);
  check_write(word_addr(4), 32'hCAFE_F00D, 4'b0000, 1'b0, 0); // no lanes, no change
  check_read(word_addr(4), 0);
endtask

task automatic test_errors();
  check_write(word_addr(REG_ID), 32'h0BAD_0BAD, 4'hF, 1'b0, 0);
  check_read(word_addr(REG_ID), 0); // still the ID constant
  check_write(word_addr(NUM_REGS), 32'h1111_2222, 4'hF, 1'b1, 0);
  check_write(12'hFFC, 32'h3333_4444, 4'hF, 1'b0, 0);
  check_read(word_addr(NUM_REGS), 0);
  check_read(12'hFF1, 0);
endtask

task automatic test_backpressure();
  logic [31:0] r;
  int          idx;
  check_write(word_addr(5), 32'h5555_AAAA, 4'hF, 1'b0, 10);
  check_read(word_addr(5), 10);
  for (int n = 0; n < 10; n++) begin
    r   = lcg_next();
    idx = 1 + r[31:24] % (NUM_REGS - 1);
    check_write(word_addr(idx), lcg_next(), 4'hF, r[0], r[23:16] % 11);
    check_read(word_addr(idx), r[15:8] % 11);
  end
endtask

task automatic test_random();
  logic [31:0] r;
  logic [31:0] s;
  axi_addr_t   addr;
  int          idx;
  for (int n = 0; n < 60; n++) begin
    r   = lcg_next();
    s   = lcg_next();
    idx = r[31:24] % (NUM_REGS + 3); // a few just past the map
    if (r[5:4] == 2'b00)
      idx = r[23:14];                 // anywhere in the address space
    addr = word_addr(idx) | axi_addr_t'(r[1:0]);
    if (r[8])
      check_write(addr, lcg_next(), s[31:28], r[9], s[23:16] % 11);
    else
      check_read(addr, s[23:16] % 11);
  end
endtask

`endif

// File: tb/tb_axi_cdc_regs.sv
// testbench for the AXI4-Lite clock-crossing interposer and its register block
// host clock 4 ns, peripheral clock 6 ns, directed tests against a word model
`timescale 1ns/1ns

module tb_axi_cdc_regs
  import axi_lite_pkg::*;
  import periph_regs_pkg::*;
();

  localparam int NUM_REGS       = 8;
  localparam int TIMEOUT_CYCLES = 4000; // ~115 accesses x ~25 cycles, plus margin

  logic     s_axi_aclk;
  logic     m_axi_aclk;
  logic     arst_n;
  aw_chan_t s_aw;
  logic     s_aw_valid;
  logic     s_aw_ready;
  w_chan_t  s_w;
  logic     s_w_valid;
  logic     s_w_ready;
  b_chan_t  s_b;
  logic     s_b_valid;
  logic     s_b_ready;
  ar_chan_t s_ar;
  logic     s_ar_valid;
  logic     s_ar_ready;
  r_chan_t  s_r;
  logic     s_r_valid;
  logic     s_r_ready;
  int       cycle_count = 0; // host cycles since time 0

  axi_cdc_regs_top #(.NUM_REGS(NUM_REGS)) i_axi_cdc_regs_top (
    .s_axi_aclk(s_axi_aclk), .m_axi_aclk(m_axi_aclk), .arst_n(arst_n),
    .s_aw(s_aw), .s_aw_valid(s_aw_valid), .s_aw_ready(s_aw_ready),
    .s_w(s_w), .s_w_valid(s_w_valid), .s_w_ready(s_w_ready),
    .s_b(s_b), .s_b_valid(s_b_valid), .s_b_ready(s_b_ready),
    .s_ar(s_ar), .s_ar_valid(s_ar_valid), .s_ar_ready(s_ar_ready),
    .s_r(s_r), .s_r_valid(s_r_valid), .s_r_ready(s_r_ready));

  initial begin
    s_axi_aclk = 1'b0;
    forever #2 s_axi_aclk = ~s_axi_aclk; // host clock
  end

  initial begin
    m_axi_aclk = 1'b0;
    forever #3 m_axi_aclk = ~m_axi_aclk; // peripheral clock
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  `include "tb_axi_tasks.svh"

  always @(posedge s_axi_aclk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
      report_failure($sformatf("Error at %0t ns: tests did not finish within %0d host cycles",
                               $time, TIMEOUT_CYCLES));
  end

  initial begin
    arst_n     = 1'b0;
    s_aw       = '0;
    s_aw_valid = 1'b0;
    s_w        = '0;
    s_w_valid  = 1'b0;
    s_b_ready  = 1'b0;
    s_ar       = '0;
    s_ar_valid = 1'b0;
    s_r_ready  = 1'b0;
    model_init();
    repeat (5) @(posedge s_axi_aclk);
    #1;
    arst_n = 1'b1;
    repeat (5) @(posedge s_axi_aclk); // both reset synchronizers release
    #1;                               // every task starts 1 ns after an edge
    test_reset_id();
    test_write_read();
    test_strobes();
    test_errors();
    test_backpressure();
    test_random();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: all.f
+incdir+tb
source/axi_lite_pkg.sv
source/periph_regs_pkg.sv
source/axi_channel_xdomain.sv
source/axi_cdc.sv
source/periph_regs.sv
source/axi_cdc_regs_top.sv
tb/tb_axi_cdc_regs.sv
